/* list.f */
+incdir+logic
logic/sandboxPkg.sv
logic/entryTable.sv
logic/queryCombiner.sv
logic/esfaCore.sv
logic/activityIndicator.sv
logic/sandboxProcess.sv
logic/sandboxTop.sv
sim/sandboxTb.sv

/* sim/sandboxTb.sv */
// sandbox testbench
// plays the host at the process ports with LFSR commands and checks
// every reply, the handshake timing and the activity blink against a model

`include "sandbox_settings.svh"

module sandboxTb
  import sandboxPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] LFSR_SEED  = 32'h5fe37156;
  localparam logic [31:0] LFSR_TAPS  = 32'hD0000001;   // x^32+x^31+x^29+x+1
  localparam int COMMAND_COUNT   = 300;
  localparam int SLOW_HALF       = 8;                  // masterClock cycles per slowClock phase
  localparam int SLOW_PERIOD     = 2 * SLOW_HALF;
  localparam int QUIET_CYCLES    = 64;                 // lets any earlier blink finish
  localparam int HANDSHAKE_LIMIT = 50;
  localparam int TX_EDGES        = 1 + 4;   // seen on the first edge, transmitData 4 later
  localparam int CLEAR_EDGES     = 2;

  logic        masterClock;
  logic        slowClock;
  logic        reset;
  logic        dataReceived;
  controlT     control;
  commandT     inputData;
  logic        clearDR;
  logic        transmitData;
  logic [7:0]  status;
  logic [31:0] outputData;
  logic        rxIndicator;

  logic [31:0] lfsrState;
  logic [7:0]  valueModel [`TABLE_DEPTH];   // reference tables
  logic [7:0]  metaModel  [`TABLE_DEPTH];
  logic [23:0] countModel;                  // accepted mutations, wraps
  int          checkCount;
  int          errorCount;
  int          timeoutCount;

  sandboxTop u_dut (
    .masterClock  (masterClock),
    .slowClock    (slowClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .rxIndicator  (rxIndicator)
  );

  // ----------------------------------------
  // clocks
  // ----------------------------------------

  initial
  begin
    masterClock = 1'b0;
    forever #5 masterClock = ~masterClock;   // 10 ns
  end

  initial
  begin
    slowClock = 1'b0;
    forever
    begin
      repeat (SLOW_HALF) @(posedge masterClock);
      slowClock <= ~slowClock;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois LFSR, one step per bit handed out
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    logic        outBit;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      outBit    = lfsrState[0];
      lfsrState = (lfsrState >> 1) ^ ({32{outBit}} & LFSR_TAPS);
      bits      = {bits[30:0], outBit};
    end
    return bits;
  endfunction

  // value against threshold, codes above NOTEQUAL never match
  function automatic logic expectMatch(input logic [7:0] sel, input logic [7:0] v,
                                       input logic [7:0] t);
    case (sel)
      8'd0    : expectMatch = (v == t);
      8'd1    : expectMatch = (v >  t);
      8'd2    : expectMatch = (v <  t);
      8'd3    : expectMatch = (v != t);
      default : expectMatch = 1'b0;
    endcase
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, what, expected, actual);
    end
  endtask

  // one full host cycle, model updated first, reply checked at clearDR
  task automatic runCommand(input controlT ctl, input commandT cmd);
    int          cycles;
    int          slot;
    logic [7:0]  expStatus;
    logic [31:0] expData;
    slot = cmd.index[`INDEX_BITS-1:0];   // upper index bits ignored
    if (ctl.isMutating)
    begin
      expStatus = 8'h01;
      expData   = 32'h0;
      if (ctl.isMeta)
        metaModel[slot] = cmd.metadata;
      else
        valueModel[slot] = cmd.value;
      countModel = countModel + 24'd1;
    end
    else
    begin
      expStatus = {7'b0, expectMatch(cmd.selector, valueModel[slot], metaModel[slot])};
      expData   = {valueModel[slot], countModel};   // value over count
    end

    @(posedge masterClock);
    control      <= ctl;
    inputData    <= cmd;
    dataReceived <= 1'b1;
    @(negedge masterClock);
    cycles = 0;
    while (!transmitData && cycles < HANDSHAKE_LIMIT)
    begin
      @(negedge masterClock);
      cycles++;
    end
    if (!transmitData)
    begin
      timeoutCount++;
      $display("timeout: transmitData never rose after dataReceived at %0t", $time);
    end
    else
    begin
      checkValue(cycles, TX_EDGES, "edges from dataReceived to transmitData");
      cycles = 0;
      while (!clearDR && cycles < HANDSHAKE_LIMIT)
      begin
        @(negedge masterClock);
        cycles++;
      end
      if (!clearDR)
      begin
        timeoutCount++;
        $display("timeout: clearDR never rose after transmitData at %0t", $time);
      end
      else
      begin
        checkValue(cycles, CLEAR_EDGES, "cycles from transmitData to clearDR");
        checkValue(status, expStatus, "status");
        checkValue(outputData, expData, "outputData");
        @(posedge masterClock);
        dataReceived <= 1'b0;
        @(negedge masterClock);
        checkValue({transmitData, clearDR}, 2'b11, "outputs on the release edge");
        @(negedge masterClock);   // one cycle after the host let go
        checkValue({transmitData, clearDR}, 2'b00, "outputs after dataReceived fell");
      end
    end
  endtask

  // blink must light within two slow periods and go out within two more
  task automatic watchIndicator();
    int cycles;
    @(posedge masterClock);   // edge the command goes out on
    @(negedge masterClock);
    checkValue(rxIndicator, 1'b0, "rxIndicator before the command");
    cycles = 0;
    while (!rxIndicator && cycles < 2 * SLOW_PERIOD)
    begin
      @(negedge masterClock);
      cycles++;
    end
    if (!rxIndicator)
    begin
      errorCount++;
      $display("failure: rxIndicator did not light within two slowClock periods");
    end
    else
    begin
      cycles = 0;
      while (rxIndicator && cycles < 2 * SLOW_PERIOD)
      begin
        @(negedge masterClock);
        cycles++;
      end
      if (rxIndicator)
      begin
        errorCount++;
        $display("failure: rxIndicator stayed lit longer than two slowClock periods");
      end
    end
  endtask

  // clearDR only ever comes on top of transmitData
  always @(negedge masterClock)
  begin
    if (reset)
      checkValue(clearDR & ~transmitData, 1'b0, "clearDR without transmitData");
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial
  begin
    controlT ctl;
    commandT cmd;
    int      cmdIndex;
    int      gap;
    lfsrState    = LFSR_SEED;
    checkCount   = 0;
    errorCount   = 0;
    timeoutCount = 0;
    countModel   = '0;
    for (int i = 0; i < `TABLE_DEPTH; i++)
    begin
      valueModel[i] = 8'h00;
      metaModel[i]  = 8'h00;
    end
    reset        = 1'b0;
    dataReceived = 1'b0;
    control      = '0;
    inputData    = '0;
    repeat (4) @(posedge masterClock);
    reset <= 1'b1;
    @(negedge masterClock);
    checkValue({transmitData, clearDR, rxIndicator}, 3'b000, "outputs after reset");

    // cleared tables, every slot reads 0 under NOTEQUAL
    for (int i = 0; i < `TABLE_DEPTH && timeoutCount == 0; i++)
    begin
      ctl          = '0;
      cmd          = '0;
      cmd.index    = 8'(i);
      cmd.selector = 8'(NOTEQUAL);
      runCommand(ctl, cmd);
    end

    cmdIndex = 0;
    while (cmdIndex < COMMAND_COUNT && timeoutCount == 0)
    begin
      ctl.reserved   = 6'(randomBits(6));
      ctl.isMeta     = randomBits(1);
      ctl.isMutating = randomBits(1);
      if (randomBits(3) == 0)
        cmd.index = 8'(randomBits(8));   // occasional out of range byte
      else
        cmd.index = 8'(randomBits(`INDEX_BITS));
      if (randomBits(3) == 7)
        cmd.selector = 8'(randomBits(8));   // mostly undefined codes
      else
        cmd.selector = 8'(randomBits(2));
      cmd.value    = 8'(randomBits(8));
      cmd.metadata = 8'(randomBits(8));
      gap          = int'(randomBits(2));
      if (cmdIndex % 25 == 0)
      begin
        for (int q = 0; q < QUIET_CYCLES; q++)
          @(posedge masterClock);
        fork
          runCommand(ctl, cmd);
          watchIndicator();
        join
      end
      else
      begin
        runCommand(ctl, cmd);
      end
      for (int g = 0; g < gap; g++)
        @(posedge masterClock);
      cmdIndex++;
    end

    $display("checks %0d mismatches %0d timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* logic/sandboxTop.sv */
// sandbox top level
// host process, table engine and activity indicator

module sandboxTop (
  input  logic        masterClock,
  input  logic        slowClock,
  input  logic        reset,
  input  logic        dataReceived,
  input  logic [7:0]  control,
  input  logic [31:0] inputData,
  output logic        clearDR,
  output logic        transmitData,
  output logic [7:0]  status,
  output logic [31:0] outputData,
  output logic        rxIndicator
);

  // ----------------------------------------
  // process to engine
  // ----------------------------------------

  logic        busy;
  logic        start;
  logic [7:0]  coreControl;
  logic [31:0] coreCommand;
  logic [32:0] result;        // match, value, count
  logic        resultValid;

  sandboxProcess u_process (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .busy         (busy),
    .start        (start),
    .coreControl  (coreControl),
    .coreCommand  (coreCommand),
    .result       (result),
    .resultValid  (resultValid)
  );

  esfaCore u_core (
    .masterClock (masterClock),
    .reset       (reset),
    .start       (start),
    .control     (coreControl),
    .command     (coreCommand),
    .result      (result),
    .resultValid (resultValid)
  );

  activityIndicator u_indicator (
    .masterClock (masterClock),
    .reset       (reset),
    .slowClock   (slowClock),
    .busy        (busy),
    .rxIndicator (rxIndicator)
  );

endmodule

/* logic/sandboxProcess.sv */
// sandbox process
// takes one host command, runs it through the engine and hands
// status and output back over the dataReceived/transmitData/clearDR cycle

module sandboxProcess
  import sandboxPkg::*;
(
  input  logic        masterClock,
  input  logic        reset,

  // host side
  input  logic        dataReceived,   // level, held until clearDR
  input  controlT     control,
  input  commandT     inputData,
  output logic        clearDR,        // ready for the next command
  output logic        transmitData,   // status and outputData valid
  output logic [7:0]  status,
  output logic [31:0] outputData,

  // engine side
  output logic        busy,
  output logic        start,
  output controlT     coreControl,
  output commandT     coreCommand,
  input  resultT      result,
  input  logic        resultValid
);

  typedef enum logic [2:0] {
    procIdle,
    procIssue,      // start pulse to the engine
    procWait,       // engine busy
    procTransmit,
    procSettle,
    procClear,
    procRelease     // host still holds dataReceived
  } procStateE;

  procStateE procState;

  // ----------------------------------------
  // engine handoff
  // ----------------------------------------

  assign start = (procState == procIssue);
  assign busy  = (procState != procIdle);

  // command latched once, held stable for the engine
  always_ff @(posedge masterClock)
  begin
    if (procState == procIdle && dataReceived)
    begin
      coreControl <= control;
      coreCommand <= inputData;
    end
  end

  // ----------------------------------------
  // command sequencer
  // ----------------------------------------

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      procState    <= procIdle;
      status       <= 8'h00;
      outputData   <= 32'h0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
    end
    else
    begin
      case (procState)
        procIdle :
        begin
          if (dataReceived)   // new command
          begin
            procState <= procIssue;
          end
        end
        procIssue :
        begin
          procState <= procWait;
        end
        procWait :
        begin
          if (resultValid)
          begin
            if (coreControl.isMutating)
            begin
              status     <= 8'h01;   // mutation accepted
              outputData <= 32'h0;
            end
            else
            begin
              status     <= {7'b0, result.match};
              outputData <= {result.value, result.count};   // value over count
            end
            procState <= procTransmit;
          end
        end
        procTransmit :
        begin
          transmitData <= 1'b1;   // 4 cycles after dataReceived seen
          procState    <= procSettle;
        end
        procSettle :
        begin
          procState <= procClear;
        end
        procClear :
        begin
          clearDR   <= 1'b1;
          procState <= procRelease;
        end
        procRelease :
        begin
          if (!dataReceived)   // may wait here for a long time
          begin
            transmitData <= 1'b0;
            clearDR      <= 1'b0;
            procState    <= procIdle;
          end
        end
        default :
        begin
          transmitData <= 1'b0;
          clearDR      <= 1'b0;
          procState    <= procIdle;
        end
      endcase
    end
  end

  // host reads the reply when it sees clearDR, so the reply must already be up
  clearNeedsTransmit: assert property (
    @(posedge masterClock) disable iff (!reset)
    clearDR |-> transmitData
  ) else $error("sandboxProcess: clearDR high without transmitData");

endmodule

/* logic/activityIndicator.sv */
// activity indicator
// one slowClock-long blink after each start of a command

module activityIndicator
  import sandboxPkg::*;
(
  input  logic masterClock,
  input  logic reset,
  input  logic slowClock,     // sampled, not used as a clock
  input  logic busy,          // process not idle
  output logic rxIndicator
);

  typedef enum logic [2:0] {
    ledIdle,
    ledArmed,      // waiting for slowClock high
    ledWaitLow,    // blink starts at the falling slowClock
    ledLitHigh,
    ledLitLow      // blink ends a full period later
  } ledStateE;

  ledStateE ledState;
  logic     busyQ;
  logic     busyRise;

  assign busyRise = busy & ~busyQ;

  // ----------------------------------------
  // blink sequencer
  // ----------------------------------------

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      ledState    <= ledIdle;
      busyQ       <= 1'b0;
      rxIndicator <= 1'b0;
    end
    else
    begin
      busyQ <= busy;
      case (ledState)
        ledIdle :
        begin
          if (busyRise)   // later rises ignored until back here
          begin
            ledState <= ledArmed;
          end
        end
        ledArmed :
        begin
          if (slowClock)
          begin
            ledState <= ledWaitLow;
          end
        end
        ledWaitLow :
        begin
          if (!slowClock)
          begin
            rxIndicator <= 1'b1;   // on
            ledState    <= ledLitHigh;
          end
        end
        ledLitHigh :
        begin
          if (slowClock)
          begin
            ledState <= ledLitLow;
          end
        end
        ledLitLow :
        begin
          if (!slowClock)
          begin
            rxIndicator <= 1'b0;   // off
            ledState    <= ledIdle;
          end
        end
        default :
        begin
          rxIndicator <= 1'b0;
          ledState    <= ledIdle;
        end
      endcase
    end
  end

endmodule

/* logic/esfaCore.sv */
// table engine
// mutations become a write on one table, queries a read on both
// followed by a compare in the combiner

module esfaCore
  import sandboxPkg::*;
(
  input  logic    masterClock,
  input  logic    reset,
  input  logic    start,        // one cycle per command
  input  controlT control,
  input  commandT command,
  output resultT  result,
  output logic    resultValid
);

  tableAccessT valueAccess;
  tableAccessT metaAccess;
  valueEntryT  valueWrite;
  valueEntryT  valueRead;
  metaEntryT   metaWrite;
  metaEntryT   metaRead;
  logic        mutated;
  logic        queryPending;     // tables answer this cycle
  compareE     querySelector;    // selector lined up with table data

  // ----------------------------------------
  // command decode
  // ----------------------------------------

  assign mutated = start & control.isMutating;

  assign valueAccess.writeStrobe = mutated & ~control.isMeta;
  assign valueAccess.index       = command.index[$bits(valueAccess.index)-1:0];
  assign valueAccess.readStrobe  = start & ~control.isMutating;

  assign metaAccess.writeStrobe  = mutated & control.isMeta;
  assign metaAccess.index        = command.index[$bits(metaAccess.index)-1:0];
  assign metaAccess.readStrobe   = start & ~control.isMutating;   // both tables read

  assign valueWrite.value     = command.value;
  assign metaWrite.threshold  = command.metadata;

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      queryPending <= 1'b0;
    end
    else
    begin
      queryPending <= valueAccess.readStrobe;
    end
  end

  // selector follows the read by one cycle
  always_ff @(posedge masterClock)
  begin
    if (valueAccess.readStrobe)
    begin
      querySelector <= compareE'(command.selector);
    end
  end

  // ----------------------------------------
  // tables and combiner
  // ----------------------------------------

  entryTable #(.entryType(valueEntryT)) u_valueTable (
    .masterClock (masterClock),
    .reset       (reset),
    .access      (valueAccess),
    .writeEntry  (valueWrite),
    .readEntry   (valueRead)
  );

  entryTable #(.entryType(metaEntryT)) u_metaTable (
    .masterClock (masterClock),
    .reset       (reset),
    .access      (metaAccess),
    .writeEntry  (metaWrite),
    .readEntry   (metaRead)
  );

  queryCombiner u_combiner (
    .masterClock (masterClock),
    .reset       (reset),
    .mutated     (mutated),
    .evaluate    (queryPending),
    .selector    (querySelector),
    .valueEntry  (valueRead),
    .metaEntry   (metaRead),
    .result      (result),
    .resultValid (resultValid)
  );

endmodule

/* logic/queryCombiner.sv */
// query combiner
// compares a stored value against its threshold, counts mutations
// and registers the engine reply

`include "sandbox_settings.svh"

module queryCombiner
  import sandboxPkg::*;
(
  input  logic       masterClock,
  input  logic       reset,
  input  logic       mutated,       // one pulse per accepted mutation
  input  logic       evaluate,      // table entries valid this cycle
  input  compareE    selector,      // rule of the pending query
  input  valueEntryT valueEntry,
  input  metaEntryT  metaEntry,
  output resultT     result,
  output logic       resultValid    // one cycle
);

  logic [23:0] mutationCount;   // wraps
  logic        mutationDone;    // mutation reply one cycle after the write
  logic        selectorKnown;
  logic        compareHit;

  // ----------------------------------------
  // compare rule
  // ----------------------------------------

  assign selectorKnown = (selector < `SELECTOR_CODES);

  always_comb
  begin
    compareHit = 1'b0;
    case (selector)
      EQUAL    : compareHit = (valueEntry.value == metaEntry.threshold);
      GREATER  : compareHit = (valueEntry.value >  metaEntry.threshold);
      LESS     : compareHit = (valueEntry.value <  metaEntry.threshold);
      NOTEQUAL : compareHit = (valueEntry.value != metaEntry.threshold);
      default  : compareHit = 1'b0;   // unknown code, no match
    endcase
  end

  // ----------------------------------------
  // counter and valid
  // ----------------------------------------

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      mutationCount <= '0;
      mutationDone  <= 1'b0;
      resultValid   <= 1'b0;
    end
    else
    begin
      if (mutated)
      begin
        mutationCount <= mutationCount + 24'd1;
      end
      mutationDone <= mutated;
      resultValid  <= evaluate | mutationDone;   // both paths take two cycles
    end
  end

  // reply payload
  always_ff @(posedge masterClock)
  begin
    if (evaluate)
    begin
      result.match <= selectorKnown & compareHit;
      result.value <= valueEntry.value;
      result.count <= mutationCount;
    end
    else if (mutationDone)
    begin
      result <= '{match: 1'b0, value: 8'h00, count: mutationCount};
    end
  end

  // process issues one command at a time, so the two paths never overlap
  pathsExclusive: assert property (
    @(posedge masterClock) disable iff (!reset)
    !(mutated && evaluate)
  ) else $error("queryCombiner: mutation and query evaluate together");

endmodule

/* logic/entryTable.sv */
// entry table
// register array of one payload type, written or read one slot per cycle

`include "sandbox_settings.svh"

module entryTable
  import sandboxPkg::*;
#(
  parameter type entryType = valueEntryT
)
(
  input  logic        masterClock,
  input  logic        reset,
  input  tableAccessT access,       // strobes and slot
  input  entryType    writeEntry,
  output entryType    readEntry     // valid one cycle after readStrobe
);

  // ----------------------------------------
  // storage
  // ----------------------------------------

  entryType tableMem [`TABLE_DEPTH];

  // table is zero after reset, host relies on it
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      for (int i = 0; i < `TABLE_DEPTH; i++)
      begin
        tableMem[i] <= '0;
      end
    end
    else if (access.writeStrobe)
    begin
      tableMem[access.index] <= writeEntry;   // mutation lands on the start edge
    end
  end

  // ----------------------------------------
  // registered read
  // ----------------------------------------

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      readEntry <= '0;
    end
    else if (access.readStrobe)
    begin
      readEntry <= tableMem[access.index];   // held until next read
    end
  end

  // engine decodes one command into either a write or a read, never both
  accessExclusive: assert property (
    @(posedge masterClock) disable iff (!reset)
    !(access.writeStrobe && access.readStrobe)
  ) else $error("entryTable: write and read strobe together");

endmodule

/* logic/sandboxPkg.sv */
// sandbox types
// host command layout, table access and query result records

`include "sandbox_settings.svh"

package sandboxPkg;

  // ----------------------------------------
  // host side
  // ----------------------------------------

  // received word, index in the low byte
  typedef struct packed {
    logic [7:0] selector;   // compare rule for queries
    logic [7:0] metadata;   // threshold for meta writes
    logic [7:0] value;      // payload for value writes
    logic [7:0] index;      // table slot
  } commandT;

  // control byte
  typedef struct packed {
    logic [5:0] reserved;
    logic       isMeta;       // mutation targets metadata table
    logic       isMutating;   // word is a mutation, else a query
  } controlT;

  // selector codes
  typedef enum logic [7:0] {
    EQUAL    = 8'd0,
    GREATER  = 8'd1,
    LESS     = 8'd2,
    NOTEQUAL = 8'd3
  } compareE;

  // ----------------------------------------
  // table side
  // ----------------------------------------

  typedef struct packed {
    logic [7:0] value;
  } valueEntryT;

  typedef struct packed {
    logic [7:0] threshold;
  } metaEntryT;

  // one table port, write and read never together
  typedef struct packed {
    logic                    writeStrobe;
    logic [`INDEX_BITS-1:0]  index;
    logic                    readStrobe;
  } tableAccessT;

  // reply of the engine
  typedef struct packed {
    logic        match;   // compare outcome
    logic [7:0]  value;   // stored value byte
    logic [23:0] count;   // accepted mutations so far
  } resultT;

endpackage

/* logic/sandbox_settings.svh */
// sandbox settings
// sizes shared by the table engine and the host process

`ifndef SANDBOX_SETTINGS_SVH
`define SANDBOX_SETTINGS_SVH

// ----------------------------------------
// table geometry
// ----------------------------------------

// entries in each of the two tables
`define TABLE_DEPTH 16

// index width, only the low bits of the index byte are used
`define INDEX_BITS 4

// ----------------------------------------
// query rules
// ----------------------------------------

// selector codes with a defined compare, higher codes never match
`define SELECTOR_CODES 4

`endif
